// ==== source/geom_pkg.sv ====
package geom_pkg;

	// signed Q16.16, 16 integer bits and 16 fraction bits
	typedef logic signed [31:0] fix_t;

	// field view of a vector, x in the top word
	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} vec_s;

	// same 96 bits seen two ways
	// comp[2] is x, comp[1] is y, comp[0] is z
	typedef union packed {
		vec_s xyz;
		fix_t [2:0] comp;
	} vec_u;

	typedef struct packed {
		vec_u origin;
		vec_u dir;
	} ray_t;

	// full 64 bit signed product, keep bits 47..16, truncated
	// sums of fix_t simply wrap modulo 2^32
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic signed [63:0] prod;
		prod = 64'(a) * 64'(b);
		return prod[47:16];
	endfunction

endpackage

// ==== source/camera_pkg.sv ====
package camera_pkg;

	// word addresses of the camera registers
	localparam logic [3:0] adr_e_x = 4'd0;
	localparam logic [3:0] adr_e_y = 4'd1;
	localparam logic [3:0] adr_e_z = 4'd2;
	localparam logic [3:0] adr_u_x = 4'd3;
	localparam logic [3:0] adr_u_y = 4'd4;
	localparam logic [3:0] adr_u_z = 4'd5;
	localparam logic [3:0] adr_v_x = 4'd6;
	localparam logic [3:0] adr_v_y = 4'd7;
	localparam logic [3:0] adr_v_z = 4'd8;
	localparam logic [3:0] adr_w_x = 4'd9;
	localparam logic [3:0] adr_w_y = 4'd10;
	localparam logic [3:0] adr_w_z = 4'd11;
	localparam logic [3:0] adr_pw = 4'd12;
	localparam logic [3:0] adr_d = 4'd13;
	// control, write only in effect
	localparam logic [3:0] adr_ctrl = 4'd14;
	// status, read only
	localparam logic [3:0] adr_status = 4'd15;

	// bit positions inside control and status
	localparam int ctrl_start_bit = 0;
	localparam int stat_busy_bit = 0;

endpackage

// ==== source/camera_if.sv ====
`timescale 1ns/1ps

interface camera_if;

	// camera setup, held constant for the whole frame
	geom_pkg::vec_u cam_e;
	geom_pkg::vec_u cam_u;
	geom_pkg::vec_u cam_v;
	geom_pkg::vec_u cam_w;
	geom_pkg::fix_t cam_pw;
	geom_pkg::fix_t cam_d;
	// one cycle start pulse, frame running flag
	logic start;
	logic busy;

	modport regs(output cam_e, cam_u, cam_v, cam_w, cam_pw, cam_d, start, input busy);
	modport scan(input start, output busy);
	modport gen(input cam_e, cam_u, cam_v, cam_w, cam_pw, cam_d);

endinterface

// ==== source/pixel_if.sv ====
`timescale 1ns/1ps

interface pixel_if #(
	parameter int screen_cols = 8,
	parameter int screen_rows = 6
);

	// coordinates held over all three phases of a pixel
	logic [$clog2(screen_cols)-1:0] pix_x;
	logic [$clog2(screen_rows)-1:0] pix_y;
	// one hot phase strobes
	logic p0, p1, p2;

	modport scan(output pix_x, pix_y, p0, p1, p2);
	modport gen(input pix_x, pix_y, p0, p1, p2);

endinterface

// ==== source/camera_regs.sv ====
`timescale 1ns/1ps

module camera_regs (
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [3:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	camera_if.regs cam
);

	logic req;
	logic wr;
	logic [31:0] rd_word;

	// new request, ack follows next cycle
	assign req = wb_cyc & wb_stb & ~wb_ack;
	// write lands at the edge that ends the ack cycle
	assign wr = wb_cyc & wb_stb & wb_we & wb_ack;

	// start only from idle, so the scanner sees it in the ack cycle
	assign cam.start = wr & ~cam.busy & (wb_adr == camera_pkg::adr_ctrl) &
		wb_dat_w[camera_pkg::ctrl_start_bit];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wb_ack <= 1'b0;
			cam.cam_e <= '0;
			cam.cam_u <= '0;
			cam.cam_v <= '0;
			cam.cam_w <= '0;
			cam.cam_pw <= '0;
			cam.cam_d <= '0;
		end else begin
			wb_ack <= req;
			// camera frozen while a frame runs, writes still acked
			if (wr && !cam.busy) begin
				case (wb_adr)
					camera_pkg::adr_e_x: cam.cam_e.xyz.x <= wb_dat_w;
					camera_pkg::adr_e_y: cam.cam_e.xyz.y <= wb_dat_w;
					camera_pkg::adr_e_z: cam.cam_e.xyz.z <= wb_dat_w;
					camera_pkg::adr_u_x: cam.cam_u.xyz.x <= wb_dat_w;
					camera_pkg::adr_u_y: cam.cam_u.xyz.y <= wb_dat_w;
					camera_pkg::adr_u_z: cam.cam_u.xyz.z <= wb_dat_w;
					camera_pkg::adr_v_x: cam.cam_v.xyz.x <= wb_dat_w;
					camera_pkg::adr_v_y: cam.cam_v.xyz.y <= wb_dat_w;
					camera_pkg::adr_v_z: cam.cam_v.xyz.z <= wb_dat_w;
					camera_pkg::adr_w_x: cam.cam_w.xyz.x <= wb_dat_w;
					camera_pkg::adr_w_y: cam.cam_w.xyz.y <= wb_dat_w;
					camera_pkg::adr_w_z: cam.cam_w.xyz.z <= wb_dat_w;
					camera_pkg::adr_pw: cam.cam_pw <= wb_dat_w;
					camera_pkg::adr_d: cam.cam_d <= wb_dat_w;
					// control handled by the start pulse, status is read only
					default: ;
				endcase
			end
		end
	end

	// read mux
	always_comb begin
		rd_word = '0;
		case (wb_adr)
			camera_pkg::adr_e_x: rd_word = cam.cam_e.xyz.x;
			camera_pkg::adr_e_y: rd_word = cam.cam_e.xyz.y;
			camera_pkg::adr_e_z: rd_word = cam.cam_e.xyz.z;
			camera_pkg::adr_u_x: rd_word = cam.cam_u.xyz.x;
			camera_pkg::adr_u_y: rd_word = cam.cam_u.xyz.y;
			camera_pkg::adr_u_z: rd_word = cam.cam_u.xyz.z;
			camera_pkg::adr_v_x: rd_word = cam.cam_v.xyz.x;
			camera_pkg::adr_v_y: rd_word = cam.cam_v.xyz.y;
			camera_pkg::adr_v_z: rd_word = cam.cam_v.xyz.z;
			camera_pkg::adr_w_x: rd_word = cam.cam_w.xyz.x;
			camera_pkg::adr_w_y: rd_word = cam.cam_w.xyz.y;
			camera_pkg::adr_w_z: rd_word = cam.cam_w.xyz.z;
			camera_pkg::adr_pw: rd_word = cam.cam_pw;
			camera_pkg::adr_d: rd_word = cam.cam_d;
			camera_pkg::adr_status: rd_word[camera_pkg::stat_busy_bit] = cam.busy;
			// control reads back as zero
			default: rd_word = '0;
		endcase
	end

	// captured with the request, valid during ack
	always_ff @(posedge clk) begin
		if (req) begin
			wb_dat_r <= rd_word;
		end
	end

endmodule

// ==== source/pixel_scan.sv ====
`timescale 1ns/1ps

module pixel_scan #(
	parameter int screen_cols = 8,
	parameter int screen_rows = 6
) (
	input logic clk,
	input logic rst,
	camera_if.scan cam,
	pixel_if.scan pix,
	output logic frame_done
);

	localparam int xw = $clog2(screen_cols);
	localparam int yw = $clog2(screen_rows);
	localparam logic [xw-1:0] x_last = xw'(screen_cols - 1);
	localparam logic [yw-1:0] y_last = yw'(screen_rows - 1);

	// phase ring, bit 0 is p0
	logic [2:0] phase;
	logic [xw-1:0] x_cnt;
	logic [yw-1:0] y_cnt;
	logic last_pix;

	assign last_pix = (x_cnt == x_last) && (y_cnt == y_last);

	assign pix.p0 = phase[0];
	assign pix.p1 = phase[1];
	assign pix.p2 = phase[2];
	assign pix.pix_x = x_cnt;
	assign pix.pix_y = y_cnt;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= 3'b000;
			x_cnt <= '0;
			y_cnt <= '0;
			cam.busy <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (!cam.busy) begin
				// first pixel starts right after the start pulse
				if (cam.start) begin
					cam.busy <= 1'b1;
					phase <= 3'b001;
					x_cnt <= '0;
					y_cnt <= '0;
				end
			end else begin
				phase <= {phase[1:0], phase[2]};
				// pixel ends on p2, step raster order x fastest
				if (phase[2]) begin
					if (last_pix) begin
						cam.busy <= 1'b0;
						phase <= 3'b000;
						frame_done <= 1'b1;
					end else if (x_cnt == x_last) begin
						x_cnt <= '0;
						y_cnt <= y_cnt + 1'b1;
					end else begin
						x_cnt <= x_cnt + 1'b1;
					end
				end
			end
		end
	end

endmodule

// ==== source/primary_ray_gen.sv ====
`timescale 1ns/1ps

module primary_ray_gen #(
	parameter int screen_cols = 8,
	parameter int screen_rows = 6
) (
	input logic clk,
	input logic rst,
	camera_if.gen cam,
	pixel_if.gen pix,
	output logic ray_valid,
	output geom_pkg::ray_t ray,
	output logic [$clog2(screen_cols)-1:0] ray_x,
	output logic [$clog2(screen_rows)-1:0] ray_y
);

	localparam int xw = $clog2(screen_cols);
	localparam int yw = $clog2(screen_rows);

	// pixel offset from screen centre, whole numbers in Q16.16
	geom_pkg::fix_t x_off;
	geom_pkg::fix_t y_off;
	// screen plane scalars
	geom_pkg::fix_t u_dist;
	geom_pkg::fix_t v_dist;
	// coordinates of the pixel in the first half of the pipe
	logic [xw-1:0] x_q;
	logic [yw-1:0] y_q;
	// component index for products and for sums
	logic [1:0] prod_idx;
	logic [1:0] sum_idx;
	geom_pkg::fix_t prod_u;
	geom_pkg::fix_t prod_v;
	geom_pkg::fix_t prod_w;
	geom_pkg::vec_u dir_q;
	// p0 delayed, bit n is high n+1 cycles after p0
	logic [4:0] stage;

	assign x_off = (int'(pix.pix_x) - screen_cols / 2) <<< 16;
	assign y_off = (int'(pix.pix_y) - screen_rows / 2) <<< 16;

	// x on p1, y on p2, z in the cycle after p2
	// that cycle is the next p0 or idle after the last pixel
	assign prod_idx = pix.p1 ? 2'd2 : (pix.p2 ? 2'd1 : 2'd0);
	// sums trail the products by one cycle
	assign sum_idx = stage[1] ? 2'd2 : (stage[2] ? 2'd1 : 2'd0);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stage <= '0;
		end else begin
			stage <= {stage[3:0], pix.p0};
		end
	end

	assign ray_valid = stage[4];

	always_ff @(posedge clk) begin
		// u and v for the new pixel
		if (pix.p0) begin
			u_dist <= geom_pkg::fix_mul(x_off, cam.cam_pw);
			v_dist <= geom_pkg::fix_mul(y_off, cam.cam_pw);
			x_q <= pix.pix_x;
			y_q <= pix.pix_y;
		end

		// one component of u*U, v*V and D*W per cycle
		// u and v still belong to the old pixel when the next p0 arrives
		prod_u <= geom_pkg::fix_mul(u_dist, cam.cam_u.comp[prod_idx]);
		prod_v <= geom_pkg::fix_mul(v_dist, cam.cam_v.comp[prod_idx]);
		prod_w <= geom_pkg::fix_mul(cam.cam_d, cam.cam_w.comp[prod_idx]);

		// wrapping sum into the direction, filled x then y then z
		if (stage[1] || stage[2] || stage[3]) begin
			dir_q.comp[sum_idx] <= prod_u + prod_v + prod_w;
		end

		// hand coordinates on before the next p0 overwrites x_q
		if (stage[1]) begin
			ray_x <= x_q;
			ray_y <= y_q;
		end
	end

	// origin is the eye point, fixed during the frame
	assign ray.origin = cam.cam_e;
	assign ray.dir = dir_q;

endmodule

// ==== source/ray_top.sv ====
`timescale 1ns/1ps

module ray_top #(
	parameter int screen_cols = 8,
	parameter int screen_rows = 6
) (
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [3:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	output logic ray_valid,
	output logic [31:0] ray_origin_x,
	output logic [31:0] ray_origin_y,
	output logic [31:0] ray_origin_z,
	output logic [31:0] ray_dir_x,
	output logic [31:0] ray_dir_y,
	output logic [31:0] ray_dir_z,
	output logic [$clog2(screen_cols)-1:0] ray_x,
	output logic [$clog2(screen_rows)-1:0] ray_y,
	output logic frame_done
);

	geom_pkg::ray_t ray;

	camera_if cam_bus ();
	pixel_if #(
		.screen_cols(screen_cols),
		.screen_rows(screen_rows)
	) pix_bus ();

	// host side register file
	camera_regs regs (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.cam(cam_bus.regs)
	);

	// raster sequencer
	pixel_scan #(
		.screen_cols(screen_cols),
		.screen_rows(screen_rows)
	) scan (
		.clk(clk),
		.rst(rst),
		.cam(cam_bus.scan),
		.pix(pix_bus.scan),
		.frame_done(frame_done)
	);

	// ray pipeline
	primary_ray_gen #(
		.screen_cols(screen_cols),
		.screen_rows(screen_rows)
	) gen (
		.clk(clk),
		.rst(rst),
		.cam(cam_bus.gen),
		.pix(pix_bus.gen),
		.ray_valid(ray_valid),
		.ray(ray),
		.ray_x(ray_x),
		.ray_y(ray_y)
	);

	// flatten the ray for the pins
	assign ray_origin_x = ray.origin.xyz.x;
	assign ray_origin_y = ray.origin.xyz.y;
	assign ray_origin_z = ray.origin.xyz.z;
	assign ray_dir_x = ray.dir.xyz.x;
	assign ray_dir_y = ray.dir.xyz.y;
	assign ray_dir_z = ray.dir.xyz.z;

endmodule

// ==== tests/ray_top_tb.sv ====
`timescale 1ns/1ps

module ray_top_tb;

	localparam int cols = 8;
	localparam int rows = 6;
	localparam int npix = cols * rows;
	localparam int xw = $clog2(cols);
	localparam int yw = $clog2(rows);
	// three frames of three cycles per pixel plus margin
	localparam int watchdog_cycles = 3 * npix * 3 + 200;
	// last ray and frame end counted from the start ack cycle
	localparam int last_ray_time = 3 * npix + 3;
	localparam int done_time = 3 * npix + 1;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [3:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	logic ray_valid;
	logic [31:0] ray_origin_x;
	logic [31:0] ray_origin_y;
	logic [31:0] ray_origin_z;
	logic [31:0] ray_dir_x;
	logic [31:0] ray_dir_y;
	logic [31:0] ray_dir_z;
	logic [xw-1:0] ray_x;
	logic [yw-1:0] ray_y;
	logic frame_done;

	// camera words as the frame should see them by register address
	logic [31:0] cam_model [14];
	logic [31:0] lfsr = 32'h17b1_43c9;
	string test_name = "init";

	// since is k during cycle a+k of a frame
	logic frame_on;
	int since;
	int ray_cnt;
	logic exp_valid;
	logic exp_done;
	logic [xw-1:0] exp_x;
	logic [yw-1:0] exp_y;
	logic [31:0] exp_dir_x;
	logic [31:0] exp_dir_y;
	logic [31:0] exp_dir_z;

	ray_top #(
		.screen_cols(cols),
		.screen_rows(rows)
	) UUT (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.ray_valid(ray_valid),
		.ray_origin_x(ray_origin_x),
		.ray_origin_y(ray_origin_y),
		.ray_origin_z(ray_origin_z),
		.ray_dir_x(ray_dir_x),
		.ray_dir_y(ray_dir_y),
		.ray_dir_z(ray_dir_z),
		.ray_x(ray_x),
		.ray_y(ray_y),
		.frame_done(frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("%s: %s", test_name, msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expv,
		input logic [31:0] actv);
		$display("error in %s, %s: expected %h actual %h", test_name, what, expv, actv);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
		end
		return bits;
	endfunction

	// signed value within about +-8.0 in Q16.16
	function automatic logic [31:0] rand_fix();
		logic [31:0] r;
		r = rand_bits(20);
		return {{12{r[19]}}, r[19:0]};
	endfunction

	// Q16.16 product keeps bits 47..16 of the 64 bit signed product
	function automatic logic [31:0] q_mul(input logic [31:0] a, input logic [31:0] b);
		longint p;
		p = longint'($signed(a)) * longint'($signed(b));
		return p[47:16];
	endfunction

	// one direction component where c is 0 for x, 1 for y and 2 for z
	function automatic logic [31:0] ref_dir(input int c, input int x, input int y);
		logic [31:0] u;
		logic [31:0] v;
		u = q_mul((x - cols / 2) * 65536, cam_model[12]);
		v = q_mul((y - rows / 2) * 65536, cam_model[12]);
		return q_mul(u, cam_model[3 + c]) + q_mul(v, cam_model[6 + c]) +
			q_mul(cam_model[13], cam_model[9 + c]);
	endfunction

	always_comb begin
		exp_valid = frame_on && since >= 6 && (since - 6) % 3 == 0;
		exp_done = frame_on && since == done_time;
		// raster order with x fastest
		exp_x = xw'(ray_cnt % cols);
		exp_y = yw'(ray_cnt / cols);
		exp_dir_x = ref_dir(0, int'(exp_x), int'(exp_y));
		exp_dir_y = ref_dir(1, int'(exp_x), int'(exp_y));
		exp_dir_z = ref_dir(2, int'(exp_x), int'(exp_y));
	end

	// cycle a is the ack of a start write while no frame runs
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			frame_on <= 1'b0;
			since <= 0;
			ray_cnt <= 0;
		end else if (!frame_on) begin
			if (wb_ack && wb_we && wb_adr == camera_pkg::adr_ctrl &&
				wb_dat_w[camera_pkg::ctrl_start_bit]) begin
				frame_on <= 1'b1;
				since <= 1;
				ray_cnt <= 0;
			end
		end else begin
			since <= since + 1;
			if (ray_valid) begin
				ray_cnt <= ray_cnt + 1;
			end
			if (since == last_ray_time) begin
				frame_on <= 1'b0;
			end
		end
	end

	// ack exactly one cycle after each new request
	assert property (@(posedge clk) disable iff (rst)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
		else report_mismatch("wb_ack after request", 32'd1, 32'd0);
	assert property (@(posedge clk) disable iff (rst)
		!(wb_cyc && wb_stb && !wb_ack) |=> !wb_ack)
		else report_mismatch("wb_ack without request", 32'd0, 32'd1);

	// ray timing and frame end
	assert property (@(posedge clk) disable iff (rst) ray_valid == exp_valid)
		else report_mismatch("ray_valid", 32'($sampled(exp_valid)), 32'($sampled(ray_valid)));
	assert property (@(posedge clk) disable iff (rst) frame_done == exp_done)
		else report_mismatch("frame_done", 32'($sampled(exp_done)),
			32'($sampled(frame_done)));

	// ray contents
	assert property (@(posedge clk) disable iff (rst) ray_valid |-> ray_x == exp_x)
		else report_mismatch("ray_x", 32'($sampled(exp_x)), 32'($sampled(ray_x)));
	assert property (@(posedge clk) disable iff (rst) ray_valid |-> ray_y == exp_y)
		else report_mismatch("ray_y", 32'($sampled(exp_y)), 32'($sampled(ray_y)));
	assert property (@(posedge clk) disable iff (rst) ray_valid |-> ray_origin_x == cam_model[0])
		else report_mismatch("origin x", $sampled(cam_model[0]), $sampled(ray_origin_x));
	assert property (@(posedge clk) disable iff (rst) ray_valid |-> ray_origin_y == cam_model[1])
		else report_mismatch("origin y", $sampled(cam_model[1]), $sampled(ray_origin_y));
	assert property (@(posedge clk) disable iff (rst) ray_valid |-> ray_origin_z == cam_model[2])
		else report_mismatch("origin z", $sampled(cam_model[2]), $sampled(ray_origin_z));
	assert property (@(posedge clk) disable iff (rst) ray_valid |-> ray_dir_x == exp_dir_x)
		else report_mismatch("dir x", $sampled(exp_dir_x), $sampled(ray_dir_x));
	assert property (@(posedge clk) disable iff (rst) ray_valid |-> ray_dir_y == exp_dir_y)
		else report_mismatch("dir y", $sampled(exp_dir_y), $sampled(ray_dir_y));
	assert property (@(posedge clk) disable iff (rst) ray_valid |-> ray_dir_z == exp_dir_z)
		else report_mismatch("dir z", $sampled(exp_dir_z), $sampled(ray_dir_z));

	// one wishbone classic access entered and left 1 ns after a rising edge
	task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
		output logic [31:0] rdata);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		do begin
			@(posedge clk);
			#1;
		end while (!wb_ack);
		rdata = wb_dat_r;
		// hold through the ack cycle since the write lands at its closing edge
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic bus_write(input logic [3:0] adr, input logic [31:0] dat);
		logic [31:0] unused_rd;
		bus_access(1'b1, adr, dat, unused_rd);
	endtask

	task automatic check_read(input logic [3:0] adr, input logic [31:0] expv, input string what);
		logic [31:0] got;
		bus_access(1'b0, adr, 32'd0, got);
		assert (got == expv) else report_mismatch(what, expv, got);
	endtask

	// fresh random camera loaded while idle so the model follows it
	task automatic load_camera();
		logic [31:0] val;
		for (int a = 0; a < 14; a++) begin
			val = rand_fix();
			bus_write(4'(a), val);
			cam_model[a] = val;
		end
	endtask

	task automatic check_camera();
		for (int a = 0; a < 14; a++) begin
			check_read(4'(a), cam_model[a], $sformatf("camera word %0d", a));
		end
	endtask

	task automatic run_frame(input bit disturb);
		bus_write(camera_pkg::adr_ctrl, 32'd1 << camera_pkg::ctrl_start_bit);
		check_read(camera_pkg::adr_status, 32'd1, "busy during frame");
		if (disturb) begin
			// these land while busy and must be dropped
			for (int a = 0; a < 14; a++) begin
				bus_write(4'(a), rand_fix());
			end
			bus_write(camera_pkg::adr_ctrl, 32'd1 << camera_pkg::ctrl_start_bit);
			check_read(camera_pkg::adr_status, 32'd1, "busy after second start");
		end
		do begin
			@(posedge clk);
			#1;
		end while (!frame_done);
		// last rays trail the frame end
		while (frame_on) begin
			@(posedge clk);
			#1;
		end
		assert (ray_cnt == npix) else report_mismatch("ray count", npix, ray_cnt);
		check_read(camera_pkg::adr_status, 32'd0, "busy after frame");
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		report_failure("watchdog expired before the tests finished");
	end

	initial begin
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		for (int a = 0; a < 14; a++) begin
			cam_model[a] = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		test_name = "reset";
		// ack, valid and done packed as three bits
		assert (!wb_ack && !ray_valid && !frame_done)
			else report_mismatch("outputs after reset", 32'd0,
				32'({wb_ack, ray_valid, frame_done}));
		for (int a = 0; a < 16; a++) begin
			check_read(4'(a), 32'd0, $sformatf("register %0d after reset", a));
		end

		test_name = "readback";
		load_camera();
		check_camera();
		check_read(camera_pkg::adr_status, 32'd0, "busy while idle");

		test_name = "frame 1";
		run_frame(1'b1);

		// writes during the frame were ignored
		test_name = "frozen camera";
		check_camera();

		test_name = "frame 2";
		load_camera();
		run_frame(1'b0);

		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== list.f ====
source/geom_pkg.sv
source/camera_pkg.sv
source/camera_if.sv
source/pixel_if.sv
source/camera_regs.sv
source/pixel_scan.sv
source/primary_ray_gen.sv
source/ray_top.sv
tests/ray_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ray generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ray_top_tb -f list.f

# a fatal stop in the testbench gives a nonzero exit status
result=$(./obj_dir/Vray_top_tb) || {
	printf '%s\n' "$result"
	exit 1
}
printf '%s\n' "$result"

# pass only when the testbench printed its pass line
printf '%s\n' "$result" | grep -qx '=== PASS ==='
